// File: src/shr_pkg.sv
`default_nettype none

package shr_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [15:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [7:0] pad;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  // GGGG GGRR RRRB BBBB
  typedef struct packed {
    logic [5:0] green;
    logic [4:0] red;
    logic [4:0] blue;
  } rgb565_t;

  // Upper half is the left pixel
  typedef union packed {
    rgb888_t          rgb888;
    rgb565_t [1:0]    mid;
  } vram_word_u;

  typedef enum logic {
    FMT_COLOR = 1'b0,
    FMT_MID   = 1'b1
  } shr_fmt_e;

  typedef struct packed {
    logic     enable;
    shr_fmt_e fmt;
    logic     pal;
  } shr_mode_t;

  typedef struct packed {
    logic       de;
    logic       hsync;
    logic       vsync;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } video_out_t;

  localparam logic [15:0] REG_MODE   = 16'd0;
  localparam logic [15:0] REG_STATUS = 16'd1;

endpackage

`default_nettype wire

// File: src/shr_raster_timer.sv
`default_nettype none

module shr_raster_timer #(
  parameter int ACTIVE_W      = 720,
  parameter int H_TOTAL       = 858,
  parameter int ACTIVE_H_NTSC = 480,
  parameter int ACTIVE_H_PAL  = 576,
  parameter int V_TOTAL_NTSC  = 525,
  parameter int V_TOTAL_PAL   = 625
) (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        pal,
  output logic      [10:0] cx,
  output logic      [9:0]  cy,
  output logic             active_x,
  output logic             active_y,
  output logic             hsync,
  output logic             vsync,
  output logic             frame_start
);

  logic [9:0] active_h;
  logic [9:0] v_total;
  logic       line_end;
  logic       last_line;

  // Frame geometry follows the standard in force
  assign active_h = pal ? 10'(ACTIVE_H_PAL) : 10'(ACTIVE_H_NTSC);
  assign v_total  = pal ? 10'(V_TOTAL_PAL) : 10'(V_TOTAL_NTSC);
  assign line_end = cx == 11'(H_TOTAL - 1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cx        <= '0;
      cy        <= '0;
      last_line <= 1'b0;
    end else if (line_end) begin
      cx <= '0;
      if (last_line) begin
        cy        <= '0;
        last_line <= 1'b0;
      end else begin
        cy        <= cy + 10'd1;
        last_line <= cy == v_total - 10'd2;
      end
    end else begin
      cx <= cx + 11'd1;
    end
  end

  assign active_x    = cx < 11'(ACTIVE_W);
  assign active_y    = cy < active_h;
  assign hsync       = cx >= 11'(ACTIVE_W + 4) && cx <= 11'(ACTIVE_W + 11);
  // First line below the picture
  assign vsync       = cy == active_h;
  assign frame_start = cx == 11'd0 && cy == 10'd0;

endmodule

`default_nettype wire

// File: src/shr_mode_ctrl.sv
`default_nettype none

module shr_mode_ctrl (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire shr_pkg::wb_req_t   wb_reg_req,
  input  wire logic               frame_start,
  output shr_pkg::wb_rsp_t        wb_reg_rsp,
  output shr_pkg::shr_mode_t      mode
);

  typedef enum logic {
    IDLE,
    ARMED
  } state_e;

  state_e             state;
  shr_pkg::shr_mode_t pending;
  logic               access;
  logic               wr_mode;
  logic               ack_q;
  logic [31:0]        dat_q;

  assign access  = wb_reg_req.cyc && wb_reg_req.stb && !ack_q;
  assign wr_mode = access && wb_reg_req.we && wb_reg_req.adr == shr_pkg::REG_MODE;

  // A later write replaces the pending mode; it lands at the next frame
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= IDLE;
      pending <= '0;
      mode    <= '0;
    end else begin
      if (wr_mode) pending <= shr_pkg::shr_mode_t'(wb_reg_req.dat[2:0]);
      case (state)
        IDLE: if (wr_mode) state <= ARMED;
        ARMED: begin
          if (frame_start && !wr_mode) begin
            mode  <= pending;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) ack_q <= 1'b0;
    else ack_q <= access;
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (wb_reg_req.adr)
        shr_pkg::REG_MODE:   dat_q <= {29'd0, mode};
        shr_pkg::REG_STATUS: dat_q <= {28'd0, state == ARMED, mode};
        default:             dat_q <= '0;
      endcase
    end
  end

  assign wb_reg_rsp = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// File: src/shr_vram.sv
`default_nettype none

module shr_vram #(
  parameter int ADDR_W = 16
) (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire shr_pkg::wb_req_t host_req,
  input  wire shr_pkg::wb_req_t fetch_req,
  output shr_pkg::wb_rsp_t      host_rsp,
  output shr_pkg::wb_rsp_t      fetch_rsp
);

  logic [31:0] mem [2**ADDR_W];
  logic        host_hit;
  logic        fetch_hit;
  logic        host_ack;
  logic        fetch_ack;
  logic [31:0] host_dat;
  logic [31:0] fetch_dat;

  assign host_hit  = host_req.cyc && host_req.stb && !host_ack;
  assign fetch_hit = fetch_req.cyc && fetch_req.stb && !fetch_ack;

  // Port A, host read and write
  always_ff @(posedge clk) begin
    if (host_hit) begin
      if (host_req.we) mem[host_req.adr[ADDR_W-1:0]] <= host_req.dat;
      host_dat <= mem[host_req.adr[ADDR_W-1:0]];
    end
  end

  // Port B, fetch reads only
  always_ff @(posedge clk) begin
    if (fetch_hit) fetch_dat <= mem[fetch_req.adr[ADDR_W-1:0]];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      host_ack  <= 1'b0;
      fetch_ack <= 1'b0;
    end else begin
      host_ack  <= host_hit;
      fetch_ack <= fetch_hit;
    end
  end

  assign host_rsp  = '{ack: host_ack, dat: host_dat};
  assign fetch_rsp = '{ack: fetch_ack, dat: fetch_dat};

endmodule

`default_nettype wire

// File: src/shr_pixel_fetch.sv
`default_nettype none

module shr_pixel_fetch #(
  parameter int ACTIVE_W = 720,
  parameter int H_TOTAL  = 858
) (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire shr_pkg::shr_mode_t mode,
  input  wire logic        [10:0] cx,
  input  wire logic        [9:0]  cy,
  input  wire logic               active_x,
  input  wire logic               active_y,
  input  wire logic               hsync,
  input  wire logic               vsync,
  input  wire shr_pkg::wb_rsp_t   fetch_rsp,
  output shr_pkg::wb_req_t        fetch_req,
  output shr_pkg::video_out_t     video
);

  localparam int WORDS = ACTIVE_W / 4;
  localparam int IDX_W = $clog2(WORDS);

  logic [31:0]         line_buf [WORDS];
  logic [IDX_W-1:0]    lb_idx;
  logic [15:0]         word_addr;
  logic                stb;
  logic                fetch_line;
  logic                next_fetch;
  logic                is_mid;
  logic                win_start;
  logic                issue;
  logic                load;
  logic                visible;
  logic [9:0]          cy_next;
  logic [31:0]         next_word;
  shr_pkg::vram_word_u cur_word;
  shr_pkg::rgb565_t    mid_px;
  logic [7:0]          red;
  logic [7:0]          green;
  logic [7:0]          blue;

  assign is_mid  = mode.fmt == shr_pkg::FMT_MID;
  assign visible = active_x && active_y;
  assign cy_next = cy + 10'd1;

  // The line after blanking is always fetched, then every 4th or 2nd line
  assign next_fetch = !active_y || (is_mid ? !cy_next[0] : cy_next[1:0] == 2'b00);

  // Prefetch window opens 8 clocks before the line
  assign win_start = cx == 11'(H_TOTAL - 8);
  // Read for group k goes out at the start of group k-1
  assign issue = fetch_line &&
                 (cx == 11'(H_TOTAL - 4) || (cx[1:0] == 2'b00 && cx < 11'(ACTIVE_W - 4)));
  // Next group's word becomes current on the last clock of a group
  assign load = cx == 11'(H_TOTAL - 1) || (cx[1:0] == 2'b11 && cx < 11'(ACTIVE_W - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stb        <= 1'b0;
      word_addr  <= '0;
      lb_idx     <= '0;
      fetch_line <= 1'b0;
    end else begin
      if (fetch_rsp.ack) begin
        stb       <= 1'b0;
        word_addr <= word_addr + 16'd1;
      end else if (issue) begin
        stb <= 1'b1;
      end
      if (win_start) begin
        fetch_line <= next_fetch;
        lb_idx     <= '0;
        // Frame restarts at word 0 after blanking
        if (!active_y) word_addr <= '0;
      end else if (load) begin
        lb_idx <= lb_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_rsp.ack) next_word <= fetch_rsp.dat;
    if (load) begin
      if (fetch_line) begin
        line_buf[lb_idx] <= next_word;
        cur_word         <= next_word;
      end else begin
        cur_word <= line_buf[lb_idx];
      end
    end
  end

  always_comb begin
    fetch_req.cyc = stb;
    fetch_req.stb = stb;
    fetch_req.we  = 1'b0;
    fetch_req.adr = word_addr;
    fetch_req.dat = '0;
  end

  // Left pixel on clocks 0 and 1 of the group
  assign mid_px = cx[1] ? cur_word.mid[0] : cur_word.mid[1];

  always_comb begin
    if (is_mid) begin
      red   = {mid_px.red, 3'b000};
      green = {mid_px.green, 2'b00};
      blue  = {mid_px.blue, 3'b000};
    end else begin
      red   = cur_word.rgb888.red;
      green = cur_word.rgb888.green;
      blue  = cur_word.rgb888.blue;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      video <= '0;
    end else begin
      video.de    <= visible;
      video.hsync <= hsync;
      video.vsync <= vsync;
      if (visible && mode.enable) begin
        video.red   <= red;
        video.green <= green;
        video.blue  <= blue;
      end else begin
        video.red   <= 8'd0;
        video.green <= 8'd0;
        video.blue  <= 8'd0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/shr_video_top.sv
`default_nettype none

module shr_video_top #(
  parameter int ACTIVE_W      = 720,
  parameter int H_TOTAL       = 858,
  parameter int ACTIVE_H_NTSC = 480,
  parameter int ACTIVE_H_PAL  = 576,
  parameter int V_TOTAL_NTSC  = 525,
  parameter int V_TOTAL_PAL   = 625,
  parameter int ADDR_W        = 16
) (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire shr_pkg::wb_req_t wb_reg_req,
  input  wire shr_pkg::wb_req_t wb_vram_req,
  output shr_pkg::wb_rsp_t      wb_reg_rsp,
  output shr_pkg::wb_rsp_t      wb_vram_rsp,
  output shr_pkg::video_out_t   video
);

  logic [10:0]        cx;
  logic [9:0]         cy;
  logic               active_x;
  logic               active_y;
  logic               hsync;
  logic               vsync;
  logic               frame_start;
  shr_pkg::shr_mode_t mode;
  shr_pkg::wb_req_t   fetch_req;
  shr_pkg::wb_rsp_t   fetch_rsp;

  shr_raster_timer #(
    .ACTIVE_W(ACTIVE_W), .H_TOTAL(H_TOTAL),
    .ACTIVE_H_NTSC(ACTIVE_H_NTSC), .ACTIVE_H_PAL(ACTIVE_H_PAL),
    .V_TOTAL_NTSC(V_TOTAL_NTSC), .V_TOTAL_PAL(V_TOTAL_PAL)
  ) shr_raster_timer_i (
    .clk(clk), .reset(reset), .pal(mode.pal),
    .cx(cx), .cy(cy), .active_x(active_x), .active_y(active_y),
    .hsync(hsync), .vsync(vsync), .frame_start(frame_start)
  );

  shr_mode_ctrl shr_mode_ctrl_i (
    .clk(clk), .reset(reset), .wb_reg_req(wb_reg_req), .frame_start(frame_start),
    .wb_reg_rsp(wb_reg_rsp), .mode(mode)
  );

  shr_vram #(.ADDR_W(ADDR_W)) shr_vram_i (
    .clk(clk), .reset(reset), .host_req(wb_vram_req), .fetch_req(fetch_req),
    .host_rsp(wb_vram_rsp), .fetch_rsp(fetch_rsp)
  );

  shr_pixel_fetch #(.ACTIVE_W(ACTIVE_W), .H_TOTAL(H_TOTAL)) shr_pixel_fetch_i (
    .clk(clk), .reset(reset), .mode(mode), .cx(cx), .cy(cy),
    .active_x(active_x), .active_y(active_y), .hsync(hsync), .vsync(vsync),
    .fetch_rsp(fetch_rsp), .fetch_req(fetch_req), .video(video)
  );

endmodule

`default_nettype wire

// File: sim/shr_tb_assert.sv
`default_nettype none

module shr_tb_assert #(
  parameter int ACTIVE_W      = 32,
  parameter int H_TOTAL       = 48,
  parameter int ACTIVE_H_NTSC = 8,
  parameter int ACTIVE_H_PAL  = 12,
  parameter int ADDR_W        = 6
) (
  input wire logic                clk,
  input wire logic                reset,
  input wire shr_pkg::wb_req_t    wb_reg_req,
  input wire shr_pkg::wb_req_t    wb_vram_req,
  input wire shr_pkg::wb_rsp_t    wb_reg_rsp,
  input wire shr_pkg::wb_rsp_t    wb_vram_rsp,
  input wire shr_pkg::video_out_t video,
  input wire shr_pkg::shr_mode_t  mode,
  input wire logic                frame_start
);

  int                 errors = 0;
  logic [31:0]        shadow_new [2**ADDR_W];
  logic [31:0]        shadow [2**ADDR_W];
  int                 x;
  int                 y;
  int                 hpos;
  logic               hs_seen;
  logic               pend;
  shr_pkg::shr_mode_t pmode;
  shr_pkg::shr_mode_t mmode;
  shr_pkg::shr_mode_t mode_q;
  int                 r;
  logic [31:0]        word;
  logic [15:0]        half;
  logic [23:0]        exp_rgb;
  logic [31:0]        host_exp;

  // Output pixels are built from the mode of the previous clock
  assign r = mode_q.fmt == shr_pkg::FMT_MID ? 2 : 4;

  // Port A read data follows the host writes
  assign host_exp = shadow_new[wb_vram_req.adr[ADDR_W-1:0]];

  always_comb begin
    word = shadow[((y / r) * (ACTIVE_W / 4) + x / 4) % (2**ADDR_W)];
    half = (x % 4) < 2 ? word[31:16] : word[15:0];
    if (!mode_q.enable) exp_rgb = '0;
    else if (mode_q.fmt == shr_pkg::FMT_MID)
      exp_rgb = {half[9:5], 3'b000, half[15:10], 2'b00, half[4:0], 3'b000};
    else exp_rgb = word[23:0];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x <= 0;
      y <= 0;
      hpos <= 0;
      hs_seen <= 1'b0;
      pend <= 1'b0;
      pmode <= '0;
      mmode <= '0;
      mode_q <= '0;
    end else begin
      mode_q <= mode;
      x <= video.de ? x + 1 : 0;
      if (video.vsync) y <= 0;
      else if (!video.de && x != 0) y <= y + 1;
      if (video.hsync && hpos > 8) hpos <= 0;
      else hpos <= hpos + 1;
      if (video.hsync) hs_seen <= 1'b1;
      if (wb_reg_req.cyc && wb_reg_req.stb && !wb_reg_rsp.ack && wb_reg_req.we &&
          wb_reg_req.adr == shr_pkg::REG_MODE) begin
        pend  <= 1'b1;
        pmode <= shr_pkg::shr_mode_t'(wb_reg_req.dat[2:0]);
      end else if (frame_start && pend) begin
        pend  <= 1'b0;
        mmode <= pmode;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_vram_req.cyc && wb_vram_req.stb && wb_vram_req.we && !wb_vram_rsp.ack)
      shadow_new[wb_vram_req.adr[ADDR_W-1:0]] <= wb_vram_req.dat;
    // Words take effect in blanking ahead of a fetched line
    if (!video.de && (y % r) == 0) shadow <= shadow_new;
  end

  assert property (@(posedge clk) reset |-> video == '0 && !wb_reg_rsp.ack && !wb_vram_rsp.ack)
    else begin errors++; $error("Error %0t: outputs active in reset", $time); end
  assert property (@(posedge clk) disable iff (reset) $fell(video.de) |-> x == ACTIVE_W)
    else begin errors++; $error("Error %0t: line has %0d de cycles", $time, x); end
  assert property (@(posedge clk) disable iff (reset)
    $rose(video.de) && hs_seen |-> hpos == H_TOTAL - ACTIVE_W - 5)
    else begin errors++; $error("Error %0t: de starts at wrong position", $time); end
  assert property (@(posedge clk) disable iff (reset)
    $fell(video.hsync) |-> hpos == 7)
    else begin errors++; $error("Error %0t: hsync width wrong", $time); end
  assert property (@(posedge clk) disable iff (reset)
    $rose(video.vsync) |-> y == (mode_q.pal ? ACTIVE_H_PAL : ACTIVE_H_NTSC))
    else begin errors++; $error("Error %0t: frame had %0d active lines", $time, y); end
  assert property (@(posedge clk) disable iff (reset)
    ($rose(video.vsync) || $fell(video.vsync)) && hs_seen |-> hpos == H_TOTAL - ACTIVE_W - 5)
    else begin errors++; $error("Error %0t: vsync edge at wrong position", $time); end
  assert property (@(posedge clk) disable iff (reset)
    wb_reg_req.cyc && wb_reg_req.stb && !wb_reg_rsp.ack |=> wb_reg_rsp.ack)
    else begin errors++; $error("Error %0t: register ack late", $time); end
  assert property (@(posedge clk) disable iff (reset)
    wb_vram_req.cyc && wb_vram_req.stb && !wb_vram_rsp.ack |=> wb_vram_rsp.ack)
    else begin errors++; $error("Error %0t: video RAM ack late", $time); end
  assert property (@(posedge clk) disable iff (reset) mode == mmode)
    else begin errors++; $error("Error %0t: mode applied at wrong time", $time); end
  assert property (@(posedge clk) disable iff (reset)
    wb_reg_req.cyc && wb_reg_req.stb && !wb_reg_rsp.ack && !wb_reg_req.we &&
    wb_reg_req.adr == shr_pkg::REG_STATUS
    |=> wb_reg_rsp.dat[3:0] == $past({pend, mmode}))
    else begin errors++; $error("Error %0t: status read mismatch", $time); end
  assert property (@(posedge clk) disable iff (reset)
    wb_reg_req.cyc && wb_reg_req.stb && !wb_reg_rsp.ack && !wb_reg_req.we &&
    wb_reg_req.adr == shr_pkg::REG_MODE
    |=> wb_reg_rsp.dat[2:0] == $past(mmode))
    else begin errors++; $error("Error %0t: mode read mismatch", $time); end
  assert property (@(posedge clk) disable iff (reset)
    wb_vram_req.cyc && wb_vram_req.stb && !wb_vram_rsp.ack && !wb_vram_req.we
    |=> wb_vram_rsp.dat == $past(host_exp))
    else begin errors++; $error("Error %0t: video RAM read mismatch", $time); end
  assert property (@(posedge clk) disable iff (reset)
    video.de |-> {video.red, video.green, video.blue} == exp_rgb)
    else begin errors++; $error("Error %0t: pixel x=%0d y=%0d wrong", $time, x, y); end
  assert property (@(posedge clk) disable iff (reset)
    !video.de |-> {video.red, video.green, video.blue} == 24'd0)
    else begin errors++; $error("Error %0t: colour outside active area", $time); end

endmodule

bind shr_video_top shr_tb_assert #(
  .ACTIVE_W(ACTIVE_W), .H_TOTAL(H_TOTAL), .ACTIVE_H_NTSC(ACTIVE_H_NTSC),
  .ACTIVE_H_PAL(ACTIVE_H_PAL), .ADDR_W(ADDR_W)
) shr_tb_assert_i (
  .clk(clk), .reset(reset), .wb_reg_req(wb_reg_req), .wb_vram_req(wb_vram_req),
  .wb_reg_rsp(wb_reg_rsp), .wb_vram_rsp(wb_vram_rsp), .video(video), .mode(mode),
  .frame_start(frame_start)
);

`default_nettype wire

// File: sim/shr_tb.sv
`default_nettype none

module shr_tb;

  localparam int ACTIVE_W = 32;
  localparam int H_TOTAL  = 48;
  localparam int V_PAL    = 16;
  localparam int ADDR_W   = 6;

  logic                clk;
  logic                reset;
  shr_pkg::wb_req_t    reg_req;
  shr_pkg::wb_req_t    vram_req;
  shr_pkg::wb_rsp_t    reg_rsp;
  shr_pkg::wb_rsp_t    vram_rsp;
  shr_pkg::video_out_t video;
  int                  seed;
  logic [31:0]         rdat;

  shr_video_top #(
    .ACTIVE_W(ACTIVE_W), .H_TOTAL(H_TOTAL), .ACTIVE_H_NTSC(8), .ACTIVE_H_PAL(12),
    .V_TOTAL_NTSC(12), .V_TOTAL_PAL(V_PAL), .ADDR_W(ADDR_W)
  ) shr_video_top_i (
    .clk(clk), .reset(reset), .wb_reg_req(reg_req), .wb_vram_req(vram_req),
    .wb_reg_rsp(reg_rsp), .wb_vram_rsp(vram_rsp), .video(video)
  );

  always #5 clk = ~clk;

  // Twelve PAL frames
  initial begin
    #(12 * H_TOTAL * V_PAL * 10);
    $display("Test failures found");
    $fatal(1, "Timeout: simulation did not finish in time");
  end

  always @(shr_video_top_i.shr_tb_assert_i.errors) begin
    if (shr_video_top_i.shr_tb_assert_i.errors != 0) begin
      $display("Test failures found");
      $fatal(1, "An assertion failed");
    end
  end

  task automatic bus_access(input logic to_vram, input logic we, input logic [15:0] adr,
                            input logic [31:0] dat, output logic [31:0] rd);
    shr_pkg::wb_req_t req;
    logic             ack;
    req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    @(posedge clk);
    #1;
    if (to_vram) vram_req = req;
    else reg_req = req;
    do begin
      @(posedge clk);
      #1;
      ack = to_vram ? vram_rsp.ack : reg_rsp.ack;
    end while (!ack);
    rd = to_vram ? vram_rsp.dat : reg_rsp.dat;
    if (to_vram) vram_req = '0;
    else reg_req = '0;
  endtask

  task automatic wait_frames(input int n);
    repeat (n) @(posedge shr_video_top_i.frame_start);
  endtask

  task automatic set_mode(input logic [2:0] m);
    bus_access(1'b0, 1'b1, shr_pkg::REG_MODE, {29'd0, m}, rdat);
    bus_access(1'b0, 1'b0, shr_pkg::REG_STATUS, '0, rdat);
    wait_frames(1);
    bus_access(1'b0, 1'b0, shr_pkg::REG_MODE, '0, rdat);
    bus_access(1'b0, 1'b0, shr_pkg::REG_STATUS, '0, rdat);
  endtask

  // New words for group 0 while line 1 repeats it
  task automatic rewrite_on_repeat();
    do begin
      @(posedge clk);
      #1;
    end while (!(shr_video_top_i.cy == 10'd1 && shr_video_top_i.cx == 11'd2));
    for (int i = 0; i < ACTIVE_W / 4; i++) begin
      bus_access(1'b1, 1'b1, 16'(i), $random(seed), rdat);
    end
  endtask

  initial begin
    seed     = 32'h90d0;
    clk      = 1'b0;
    reset    = 1'b1;
    reg_req  = '0;
    vram_req = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int a = 0; a < 2**ADDR_W; a++) begin
      bus_access(1'b1, 1'b1, 16'(a), $random(seed), rdat);
    end

    // Read the fill back through port A
    for (int a = 0; a < 2**ADDR_W; a++) begin
      bus_access(1'b1, 1'b0, 16'(a), '0, rdat);
    end

    // Colour format, NTSC
    set_mode(3'b100);
    wait_frames(2);
    rewrite_on_repeat();
    wait_frames(2);

    // Mid format, PAL
    set_mode(3'b111);
    wait_frames(2);
    rewrite_on_repeat();
    wait_frames(2);

    // Display off
    set_mode(3'b010);
    wait_frames(2);

    @(posedge clk);
    #1;
    if (shr_video_top_i.shr_tb_assert_i.errors == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "Assertions reported errors");
    end
  end

endmodule

`default_nettype wire

// File: flist.f
src/shr_pkg.sv
src/shr_raster_timer.sv
src/shr_mode_ctrl.sv
src/shr_vram.sv
src/shr_pixel_fetch.sv
src/shr_video_top.sv
sim/shr_tb_assert.sv
sim/shr_tb.sv

// File: Makefile
TOP = shr_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

# Exit status comes from the search for the pass line
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
